// File: hdl/bn_config.svh
`ifndef BN_CONFIG_SVH
`define BN_CONFIG_SVH

// ****************************************
// layer geometry
// ****************************************
`define BN_CHANNELS   6   // channels per vector.
`define BN_CH_W       3   // channel index width.

// ****************************************
// fixed-point formats
// ****************************************
`define BN_DATA_W     8   // signed sample, mean and beta width.
`define BN_FRAC_W     4   // fraction bits of sample, mean and beta.
`define BN_SCALE_W    12  // signed scale width (gamma / std).
`define BN_SCALE_FRAC 8   // fraction bits of the scale.

`endif

// File: hdl/bn_datapath.sv
`default_nettype none

`include "bn_config.svh"

module bn_datapath
    import bn_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  bn_vec_t       data_in,
    input  logic          valid_in,
    input  bn_param_vec_t params,
    output bn_vec_t       data_out,
    output logic          valid_out
);

    localparam int NUM_CH     = `BN_CHANNELS;
    localparam int PIPE_DEPTH = 3;                           // input edge to valid_out.

    logic [PIPE_DEPTH-1:0] valid_sr;                         // bit n follows stage n+1.
    bn_vec_t               lane_out;

    // ****************************************
    // channel lanes
    // ****************************************
    for (genvar ch = 0; ch < NUM_CH; ch++)
    begin : g_lane
        bn_lane u_lane (
            .clk    (clk),
            .rst_n  (rst_n),
            .sample (data_in[ch]),
            .param  (params[ch]),
            .result (lane_out[ch])
        );
    end

    // ****************************************
    // valid tracking and output register
    // ****************************************
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid_sr <= '0;
        end
        else
        begin
            valid_sr <= {valid_sr[PIPE_DEPTH-2:0], valid_in};
        end
    end

    // loads with the item leaving stage 2, holds otherwise.
    always_ff @(posedge clk)
    begin
        if (valid_sr[PIPE_DEPTH-2])
        begin
            data_out <= lane_out;
        end
    end

    assign valid_out = valid_sr[PIPE_DEPTH-1];

endmodule

`default_nettype wire

// File: hdl/bn_lane.sv
`default_nettype none

`include "bn_config.svh"

module bn_lane
    import bn_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  bn_data_t  sample,
    input  bn_param_t param,
    output bn_data_t  result
);

    localparam int DIFF_W    = `BN_DATA_W + 1;              // x - mean never overflows.
    localparam int PROD_W    = DIFF_W + `BN_SCALE_W;        // full product width.
    localparam int PROD_FRAC = `BN_FRAC_W + `BN_SCALE_FRAC;
    localparam int SHIFT     = PROD_FRAC - `BN_FRAC_W;      // back to the data format.

    localparam logic signed [PROD_W-1:0] ROUND_C = 1 << (SHIFT - 1);            // half lsb.
    localparam logic signed [PROD_W-1:0] SAT_MAX = (1 << (`BN_DATA_W - 1)) - 1;
    localparam logic signed [PROD_W-1:0] SAT_MIN = -(1 << (`BN_DATA_W - 1));

    typedef struct packed {
        logic signed [DIFF_W-1:0] diff;
        bn_scale_t                scale;
        bn_data_t                 beta;
    } stage1_t;

    typedef struct packed {
        logic signed [PROD_W-1:0] prod;
        bn_data_t                 beta;
    } stage2_t;

    stage1_t s1_d;
    stage1_t s1_q;
    stage2_t s2_d;
    stage2_t s2_q;

    logic signed [PROD_W-1:0] rounded;
    logic signed [PROD_W-1:0] sum;

    // ****************************************
    // stage 1: centre the sample
    // ****************************************
    // scale and beta ride along so later writes leave this item alone.
    always_comb
    begin
        s1_d.diff  = DIFF_W'(sample) - DIFF_W'(param.mean);
        s1_d.scale = param.scale;
        s1_d.beta  = param.beta;
    end

    // ****************************************
    // stage 2: scale
    // ****************************************
    always_comb
    begin
        s2_d.prod = s1_q.diff * s1_q.scale;                  // 12 fraction bits.
        s2_d.beta = s1_q.beta;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            s1_q <= '0;
            s2_q <= '0;
        end
        else
        begin
            s1_q <= s1_d;
            s2_q <= s2_d;
        end
    end

    // ****************************************
    // stage 3: round, offset, saturate
    // ****************************************
    // registered by the datapath output stage.
    always_comb
    begin
        rounded = (s2_q.prod + ROUND_C) >>> SHIFT;           // round half up.
        sum     = rounded + s2_q.beta;                       // beta sign-extends.
        if (sum > SAT_MAX)
        begin
            result = SAT_MAX[`BN_DATA_W-1:0];
        end
        else if (sum < SAT_MIN)
        begin
            result = SAT_MIN[`BN_DATA_W-1:0];
        end
        else
        begin
            result = sum[`BN_DATA_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: hdl/bn_param_regs.sv
`default_nettype none

`include "bn_config.svh"

module bn_param_regs
    import bn_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          cfg_we,
    input  bn_cfg_t       cfg,
    output bn_param_vec_t params
);

    localparam int NUM_CH = `BN_CHANNELS;
    localparam int CH_W   = `BN_CH_W;

    logic [NUM_CH-1:0] wr_hit;                               // one-hot slot select.

    // ****************************************
    // write decode
    // ****************************************
    // indices past the last channel match no slot and are dropped.
    always_comb
    begin
        for (int ch = 0; ch < NUM_CH; ch++)
        begin
            wr_hit[ch] = cfg_we && (cfg.channel == CH_W'(ch));
        end
    end

    // ****************************************
    // parameter slots
    // ****************************************
    for (genvar ch = 0; ch < NUM_CH; ch++)
    begin : g_slot
        bn_param_t slot_q;

        always_ff @(posedge clk)
        begin
            if (!rst_n)
            begin
                slot_q <= BN_PARAM_IDENTITY;                 // pass-through after reset.
            end
            else if (wr_hit[ch])
            begin
                slot_q <= cfg.param;
            end
        end

        assign params[ch] = slot_q;                          // visible one cycle after the strobe.
    end

endmodule

`default_nettype wire

// File: hdl/bn_pkg.sv
`default_nettype none

`include "bn_config.svh"

package bn_pkg;

    // ****************************************
    // sample types
    // ****************************************
    typedef logic signed [`BN_DATA_W-1:0] bn_data_t;         // one sample.
    typedef bn_data_t [`BN_CHANNELS-1:0] bn_vec_t;           // channel 0 in the low bits.

    // ****************************************
    // per-channel parameters
    // ****************************************
    typedef logic signed [`BN_SCALE_W-1:0] bn_scale_t;       // gamma / sqrt(var + eps).

    typedef struct packed {
        bn_data_t  mean;                                     // running mean.
        bn_scale_t scale;                                    // precomputed multiplier.
        bn_data_t  beta;                                     // output offset.
    } bn_param_t;

    typedef bn_param_t [`BN_CHANNELS-1:0] bn_param_vec_t;

    // one write on the config port
    typedef struct packed {
        logic [`BN_CH_W-1:0] channel;                        // target channel.
        bn_param_t           param;                          // new parameter set.
    } bn_cfg_t;

    // identity transform: y = (x - 0) * 1.0 + 0.
    localparam bn_param_t BN_PARAM_IDENTITY = '{
        mean:  '0,
        scale: bn_scale_t'(1 << `BN_SCALE_FRAC),
        beta:  '0
    };

endpackage

`default_nettype wire

// File: hdl/bn_top.sv
`default_nettype none

module bn_top
    import bn_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  bn_vec_t data_in,
    input  logic    valid_in,
    input  logic    cfg_we,
    input  bn_cfg_t cfg,
    output bn_vec_t data_out,
    output logic    valid_out
);

    bn_param_vec_t params;                                   // live per-channel parameters.

    // ****************************************
    // configuration registers
    // ****************************************
    bn_param_regs u_param_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .cfg_we (cfg_we),
        .cfg    (cfg),
        .params (params)
    );

    // ****************************************
    // normalization pipeline
    // ****************************************
    bn_datapath u_datapath (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_in   (data_in),
        .valid_in  (valid_in),
        .params    (params),
        .data_out  (data_out),
        .valid_out (valid_out)
    );

endmodule

`default_nettype wire

// File: list.f
+incdir+hdl
hdl/bn_pkg.sv
hdl/bn_param_regs.sv
hdl/bn_lane.sv
hdl/bn_datapath.sv
hdl/bn_top.sv
verif/bn_chk.sv
verif/bn_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the batch normalization testbench with Verilator.

cd "$(dirname "$0")" || exit 1

TOP=bn_tb
MDIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -j 0 \
        --timescale 1ns/1ps \
        --top-module "$TOP" \
        -f list.f \
        --Mdir "$MDIR" -o "$TOP"; then
    echo "verilator build failed"
    exit 1
fi

"./$MDIR/$TOP" > "$LOG" 2>&1
status=$?

if ! cat "$LOG"; then
    echo "could not read $LOG"
    exit 1
fi

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation completed successfully$" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: verif/bn_chk.sv
`default_nettype none

module bn_chk
    import bn_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input logic    valid_in,
    input logic    valid_out,
    input bn_vec_t data_out
);

    timeunit 1ns;
    timeprecision 1ps;

    // ****************************************
    // reset behaviour
    // ****************************************
    property p_idle_after_reset;
        @(posedge clk) !rst_n |=> !valid_out;
    endproperty

    a_idle_after_reset : assert property (p_idle_after_reset)
        else $error("valid_out high in the cycle after reset");

    // ****************************************
    // pipeline timing
    // ****************************************
    // three register stages between valid_in and valid_out.
    property p_valid_latency;
        @(posedge clk) disable iff (!rst_n)
            valid_out == $past(valid_in, 3);
    endproperty

    a_valid_latency : assert property (p_valid_latency)
        else $error("valid_out does not follow valid_in by three cycles");

    property p_data_known;
        @(posedge clk) disable iff (!rst_n)
            valid_out |-> !$isunknown(data_out);
    endproperty

    a_data_known : assert property (p_data_known)
        else $error("data_out has unknown bits while valid_out is high");

endmodule

`default_nettype wire

// File: verif/bn_tb.sv
`default_nettype none

`include "bn_config.svh"

module bn_tb
    import bn_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CH      = `BN_CHANNELS;
    localparam int PIPE_DEPTH  = 3;                          // input edge to valid_out.
    localparam int SHIFT       = `BN_SCALE_FRAC;             // 12 fraction bits down to 4.
    localparam int ROUND_HALF  = 1 << (`BN_SCALE_FRAC - 1);
    localparam int SAT_HI      = (1 << (`BN_DATA_W - 1)) - 1;
    localparam int SAT_LO      = -(1 << (`BN_DATA_W - 1));
    localparam int RANDOM_VECS = 1500;
    localparam int MAX_CYCLES  = 4000;                       // tests take about 2500 cycles.

    logic    clk;
    logic    rst_n;
    bn_vec_t data_in;
    logic    valid_in;
    logic    cfg_we;
    bn_cfg_t cfg;
    bn_vec_t data_out;
    logic    valid_out;

    bn_param_vec_t         shadow;                           // model copy of the registers.
    bn_vec_t               exp_q[$];                         // expected vectors in flight.
    logic [PIPE_DEPTH-1:0] valid_hist;                       // valid_in of the last cycles.
    logic [31:0]           rng_state;
    int                    cycle_cnt;
    int                    vectors_sent;
    int                    outputs_checked;
    int                    valid_errors;
    int                    data_errors;
    int                    other_errors;
    int                    sat_hi_seen;
    int                    sat_lo_seen;

    bn_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_in   (data_in),
        .valid_in  (valid_in),
        .cfg_we    (cfg_we),
        .cfg       (cfg),
        .data_out  (data_out),
        .valid_out (valid_out)
    );

    bind bn_top bn_chk u_chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .valid_out (valid_out),
        .data_out  (data_out)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #20 clk = ~clk;
        end
    end

    // ****************************************
    // random numbers and reference model
    // ****************************************
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic bn_vec_t rand_vec();
        bn_vec_t     v;
        logic [31:0] r;
        for (int ch = 0; ch < NUM_CH; ch++)
        begin
            r = next_rand();
            v[ch] = bn_data_t'(r[7:0]);
        end
        return v;
    endfunction

    function automatic bn_param_t make_param(input int mean, input int scale, input int beta);
        bn_param_t p;
        p.mean  = bn_data_t'(mean);
        p.scale = bn_scale_t'(scale);
        p.beta  = bn_data_t'(beta);
        return p;
    endfunction

    function automatic bn_param_t rand_param();
        logic [31:0] r;
        r = next_rand();
        return make_param($signed(r[7:0]), $signed(r[19:8]), $signed(r[27:20]));
    endfunction

    // y = sat(round((x - mean) * scale) + beta).
    function automatic bn_data_t norm_value(input bn_data_t x, input bn_param_t p);
        int diff;
        int prod;
        int y;
        diff = int'($signed(x)) - int'($signed(p.mean));
        prod = diff * int'($signed(p.scale));
        y    = ((prod + ROUND_HALF) >>> SHIFT) + int'($signed(p.beta));
        if (y > SAT_HI)
        begin
            y = SAT_HI;
        end
        else if (y < SAT_LO)
        begin
            y = SAT_LO;
        end
        return bn_data_t'(y);
    endfunction

    function automatic bn_vec_t model_vec(input bn_vec_t din);
        bn_vec_t v;
        for (int ch = 0; ch < NUM_CH; ch++)
        begin
            v[ch] = norm_value(din[ch], shadow[ch]);
        end
        return v;
    endfunction

    // ****************************************
    // scoreboard and cycle driver
    // ****************************************
    task automatic note_saturation(input bn_vec_t v);
        for (int ch = 0; ch < NUM_CH; ch++)
        begin
            if (int'($signed(v[ch])) == SAT_HI)
            begin
                sat_hi_seen++;
            end
            if (int'($signed(v[ch])) == SAT_LO)
            begin
                sat_lo_seen++;
            end
        end
    endtask

    task automatic check_outputs();
        bn_vec_t expected;
        assert (valid_out === valid_hist[PIPE_DEPTH-1])
        else
        begin
            valid_errors++;
            $display("error: valid_out got %h expected %h", valid_out, valid_hist[PIPE_DEPTH-1]);
        end
        if (valid_out === 1'b1)
        begin
            outputs_checked++;
            assert (exp_q.size() != 0)
            else
            begin
                other_errors++;
                $display("an output arrived with no vector waiting for it");
            end
            if (exp_q.size() != 0)
            begin
                expected = exp_q.pop_front();
                assert (data_out === expected)
                else
                begin
                    data_errors++;
                    $display("error: data_out got %h expected %h", data_out, expected);
                end
                note_saturation(data_out);
            end
        end
    endtask

    // one falling edge: check what the last rising edge produced, then drive.
    task automatic drive_cycle(input logic vld, input bn_vec_t din, input logic we,
                               input bn_cfg_t c);
        @(negedge clk);
        check_outputs();
        if (vld)
        begin
            exp_q.push_back(model_vec(din));                 // params seen at entry.
            vectors_sent++;
        end
        if (we && int'(c.channel) < NUM_CH)
        begin
            shadow[c.channel] = c.param;
        end
        valid_hist = {valid_hist[PIPE_DEPTH-2:0], vld};
        valid_in   = vld;
        data_in    = din;
        cfg_we     = we;
        cfg        = c;
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, rand_vec(), 1'b0, '0);
    endtask

    task automatic write_param(input int ch, input bn_param_t p);
        bn_cfg_t c;
        c.channel = ch[`BN_CH_W-1:0];
        c.param   = p;
        drive_cycle(1'b0, rand_vec(), 1'b1, c);
    endtask

    task automatic drain_pipeline();
        while (exp_q.size() != 0)
        begin
            idle_cycle();
        end
        repeat (PIPE_DEPTH + 1)
        begin
            idle_cycle();                                    // valid_out must stay low.
        end
    endtask

    // ****************************************
    // tests
    // ****************************************
    task automatic identity_test();
        logic [31:0] r;
        for (int i = 0; i < 60; i++)
        begin
            r = next_rand();
            drive_cycle(r[1:0] != 2'd0, rand_vec(), 1'b0, '0);
        end
        drain_pipeline();
    endtask

    task automatic random_param_test();
        logic [31:0] r;
        int          sent;
        for (int ch = 0; ch < NUM_CH; ch++)
        begin
            write_param(ch, rand_param());
        end
        sent = 0;
        while (sent < RANDOM_VECS)
        begin
            r = next_rand();
            if (r[2:0] == 3'd0)
            begin
                idle_cycle();                                // occasional gap.
            end
            else
            begin
                drive_cycle(1'b1, rand_vec(), 1'b0, '0);
                sent++;
            end
        end
        drain_pipeline();
    endtask

    task automatic saturation_test();
        bn_vec_t     v;
        logic [31:0] r;
        write_param(0, make_param(0, 2047, 127));
        write_param(1, make_param(0, 2047, -128));
        write_param(2, make_param(0, -2048, 0));
        write_param(3, make_param(-128, 1024, 127));
        write_param(4, make_param(127, -2048, -128));
        write_param(5, make_param(0, 2047, 0));
        sat_hi_seen = 0;
        sat_lo_seen = 0;
        for (int i = 0; i < 24; i++)
        begin
            v = rand_vec();
            for (int ch = 0; ch < NUM_CH; ch++)
            begin
                r = next_rand();
                if (r[1:0] == 2'd0)
                begin
                    v[ch] = bn_data_t'(SAT_HI);
                end
                else if (r[1:0] == 2'd1)
                begin
                    v[ch] = bn_data_t'(SAT_LO);
                end
            end
            drive_cycle(1'b1, v, 1'b0, '0);
        end
        drain_pipeline();
        assert (sat_hi_seen > 0 && sat_lo_seen > 0)
        else
        begin
            other_errors++;
            $display("the saturation test did not reach both output limits");
        end
    endtask

    task automatic ignored_index_test();
        logic [31:0] r;
        bn_cfg_t     c;
        for (int i = 0; i < 120; i++)
        begin
            r = next_rand();
            c.channel = r[4] ? 3'd7 : 3'd6;                  // past the last channel.
            c.param   = rand_param();
            drive_cycle(r[1:0] != 2'd0, rand_vec(), r[2], c);
        end
        drain_pipeline();
    endtask

    task automatic param_timing_test();
        logic [31:0] r;
        bn_cfg_t     c;
        for (int i = 0; i < 300; i++)
        begin
            r = next_rand();
            c.channel = 3'(r[15:8] % NUM_CH);
            c.param   = rand_param();
            drive_cycle(r[1:0] != 2'd0, rand_vec(), r[2], c);  // writes land mid-flight.
        end
        drain_pipeline();
    endtask

    // ****************************************
    // watchdog and main sequence
    // ****************************************
    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        rst_n           = 1'b0;
        data_in         = '0;
        valid_in        = 1'b0;
        cfg_we          = 1'b0;
        cfg             = '0;
        valid_hist      = '0;
        rng_state       = 32'hc1787479;
        vectors_sent    = 0;
        outputs_checked = 0;
        valid_errors    = 0;
        data_errors     = 0;
        other_errors    = 0;
        sat_hi_seen     = 0;
        sat_lo_seen     = 0;
        for (int ch = 0; ch < NUM_CH; ch++)
        begin
            shadow[ch] = make_param(0, 1 << `BN_SCALE_FRAC, 0);   // reset is identity.
        end

        repeat (8)
        begin
            idle_cycle();
        end
        rst_n = 1'b1;

        identity_test();
        random_param_test();
        saturation_test();
        ignored_index_test();
        param_timing_test();

        assert (outputs_checked == vectors_sent)
        else
        begin
            other_errors++;
            $display("sent %0d vectors but checked %0d outputs", vectors_sent, outputs_checked);
        end

        $display("errors: valid_out %0d, data_out %0d, other %0d",
                 valid_errors, data_errors, other_errors);
        if (valid_errors + data_errors + other_errors == 0)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
